//--- hdl/audioTxPkg.sv
// Shared types and constants for the audio transmit block
// Sample word layout, bus widths and the CSR offset map
// Import with a wildcard in the module header where needed

package audioTxPkg;

	//----------------------------------------------------------
	// Sample word
	//----------------------------------------------------------
	localparam int cSampleBits  = 16;			// Bits per channel
	localparam int cBusDataBits = 32;			// Bus and RAM word width
	localparam int cCntBits     = 16;			// Status counter width

	typedef struct packed
	{
		logic [cSampleBits-1:0] left;			// Upper half, sent first
		logic [cSampleBits-1:0] right;			// Lower half
	} tSampleCh;

	// One word seen as a raw bus word or as a stereo pair
	typedef union packed
	{
		logic [cBusDataBits-1:0] raw;
		tSampleCh                ch;
	} tSampleWord;

	//----------------------------------------------------------
	// CSR offsets
	//----------------------------------------------------------
	localparam logic [7:0] cCsrStatus   = 8'h00;	// Bit 0 busy, read only
	localparam logic [7:0] cCsrLoopCnt  = 8'h04;	// Completed passes, read only
	localparam logic [7:0] cCsrUnderrun = 8'h08;	// Empty frames, read only
	localparam logic [7:0] cCsrRsvd     = 8'h0c;	// Reserved, reads zero
	localparam logic [7:0] cCsrDmaAdrs  = 8'h10;	// Start word address
	localparam logic [7:0] cCsrDmaLen   = 8'h14;	// Last word offset
	localparam logic [7:0] cCsrDmaEn    = 8'h18;	// Bit 0 enable

endpackage

//--- hdl/audioTxCsr.sv
// Control and status registers of the audio transmit block
// Holds the DMA setup written by the host and returns status
// Read data and read valid come out registered, one cycle after the address

module audioTxCsr
	import audioTxPkg::*;
#(
	parameter int                       pBlockAdrsMap   = 8,
	parameter int                       pCsrAdrsWidth   = 16,
	parameter int                       pBusAdrsBit     = 24,
	parameter int                       pCsrActiveWidth = 8,
	parameter logic [pBlockAdrsMap-1:0] pCsrMap         = 'h05,
	parameter int                       pMemAdrsWidth   = 8
)(
	// Bus slave
	input  logic [cBusDataBits-1:0]  iSUsiWd,		// Write data
	input  logic [pBusAdrsBit-1:0]   iSUsiAdrs,		// Read/write address
	input  logic                     iSUsiWCke,		// Write strobe
	output logic [cBusDataBits-1:0]  oSUsiRd,		// Read data
	output logic                     oSUsiREd,		// Read valid level
	// Status in
	input  logic                     dmaBusy,
	input  logic [cCntBits-1:0]      loopCnt,
	input  logic [cCntBits-1:0]      underrunCnt,
	// DMA setup out
	output logic [pMemAdrsWidth-1:0] dmaAdrs,
	output logic [pMemAdrsWidth-1:0] dmaLen,
	output logic                     dmaEn,
	// Clock and reset
	input  logic                     iSysClk,
	input  logic                     reset
);

	logic [pBlockAdrsMap-1:0]   blockSel;			// Block field of the address
	logic [pCsrActiveWidth-1:0] csrOfs;				// Decoded offset bits
	logic                       inBlock;
	logic                       wrAdrs;
	logic                       wrLen;
	logic                       wrEn;
	logic [cBusDataBits-1:0]    rdWord;				// Read mux result

	assign blockSel = iSUsiAdrs[pBlockAdrsMap+pCsrAdrsWidth-1:pCsrAdrsWidth];
	assign csrOfs   = iSUsiAdrs[pCsrActiveWidth-1:0];
	assign inBlock  = (blockSel == pCsrMap);

	// Write strobes per register
	assign wrAdrs = iSUsiWCke & inBlock & (csrOfs == cCsrDmaAdrs);
	assign wrLen  = iSUsiWCke & inBlock & (csrOfs == cCsrDmaLen);
	assign wrEn   = iSUsiWCke & inBlock & (csrOfs == cCsrDmaEn);

	//----------------------------------------------------------
	// DMA setup registers
	//----------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (reset)
		begin
			dmaAdrs <= '0;
			dmaLen  <= '0;
			dmaEn   <= 1'b0;
		end
		else
		begin
			if (wrAdrs) dmaAdrs <= iSUsiWd[pMemAdrsWidth-1:0];	// Masked to RAM size
			if (wrLen)  dmaLen  <= iSUsiWd[pMemAdrsWidth-1:0];
			if (wrEn)   dmaEn   <= iSUsiWd[0];
		end
	end

	//----------------------------------------------------------
	// Read path
	//----------------------------------------------------------
	// Zero fill above each field
	always_comb
	begin
		case (csrOfs)
			cCsrStatus:   rdWord = {{(cBusDataBits-1){1'b0}}, dmaBusy};
			cCsrLoopCnt:  rdWord = {{(cBusDataBits-cCntBits){1'b0}}, loopCnt};
			cCsrUnderrun: rdWord = {{(cBusDataBits-cCntBits){1'b0}}, underrunCnt};
			cCsrRsvd:     rdWord = '0;
			cCsrDmaAdrs:  rdWord = {{(cBusDataBits-pMemAdrsWidth){1'b0}}, dmaAdrs};
			cCsrDmaLen:   rdWord = {{(cBusDataBits-pMemAdrsWidth){1'b0}}, dmaLen};
			cCsrDmaEn:    rdWord = {{(cBusDataBits-1){1'b0}}, dmaEn};
			default:      rdWord = '0;						// Unmapped reads zero
		endcase
	end

	always_ff @(posedge iSysClk)
	begin
		if (reset)
			oSUsiREd <= 1'b0;
		else
			oSUsiREd <= inBlock;							// Any in-block address

		if (inBlock)
			oSUsiRd <= rdWord;								// Hold last word otherwise
	end

endmodule

//--- hdl/audioSampleRam.sv
// Sample RAM for the audio transmit block
// The host writes 32-bit sample words through its own bus block
// The DMA reads one word per request, data one cycle later

module audioSampleRam
	import audioTxPkg::*;
#(
	parameter int                       pBlockAdrsMap = 8,
	parameter int                       pCsrAdrsWidth = 16,
	parameter int                       pBusAdrsBit   = 24,
	parameter logic [pBlockAdrsMap-1:0] pRamMap       = 'h06,
	parameter int                       pMemAdrsWidth = 8
)(
	input  logic [cBusDataBits-1:0]  iSUsiWd,		// Write data
	input  logic [pBusAdrsBit-1:0]   iSUsiAdrs,		// Byte address
	input  logic                     iSUsiWCke,		// Write strobe
	input  logic [pMemAdrsWidth-1:0] ramRdAdrs,		// DMA word address
	input  logic                     ramRdEn,
	output tSampleWord               ramRdData,
	input  logic                     iSysClk
);

	localparam int cWords = 2**pMemAdrsWidth;		// 256 by default

	tSampleWord               mem [cWords];
	logic [pBlockAdrsMap-1:0] blockSel;
	logic [pMemAdrsWidth-1:0] wrAdrs;				// Word index from byte address
	logic                     wrHit;

	assign blockSel = iSUsiAdrs[pBlockAdrsMap+pCsrAdrsWidth-1:pCsrAdrsWidth];
	assign wrAdrs   = iSUsiAdrs[pMemAdrsWidth+1:2];
	assign wrHit    = iSUsiWCke & (blockSel == pRamMap);

	// Bus write port
	always_ff @(posedge iSysClk)
	begin
		if (wrHit)
			mem[wrAdrs].raw <= iSUsiWd;
	end

	// Registered read for the DMA
	always_ff @(posedge iSysClk)
	begin
		if (ramRdEn)
			ramRdData <= mem[ramRdAdrs];
	end

endmodule

//--- hdl/audioTxDma.sv
// Looping DMA reader from the sample RAM into the sample FIFO
// Reads run while enabled and stall when the FIFO would fill up
// Disabling flushes the FIFO and parks the pointer at the start address

module audioTxDma
	import audioTxPkg::*;
#(
	parameter int pMemAdrsWidth = 8,
	parameter int pFifoDepthBit = 3
)(
	// Setup from the CSR
	input  logic [pMemAdrsWidth-1:0] dmaAdrs,
	input  logic [pMemAdrsWidth-1:0] dmaLen,		// Length minus one
	input  logic                     dmaEn,
	// RAM read port
	output logic [pMemAdrsWidth-1:0] ramRdAdrs,
	output logic                     ramRdEn,
	input  tSampleWord               ramRdData,
	// FIFO write side
	input  logic [pFifoDepthBit:0]   fifoCount,
	output logic                     fifoWr,
	output tSampleWord               fifoWd,
	output logic                     fifoFlush,
	// Status
	output logic                     dmaBusy,
	output logic [cCntBits-1:0]      loopCnt,
	input  logic                     iSysClk,
	input  logic                     reset
);

	localparam int cDepth = 2**pFifoDepthBit;

	logic                     enD;					// Enable one cycle ago
	logic [pMemAdrsWidth-1:0] rdPtr;
	logic [pMemAdrsWidth-1:0] rdOfs;				// Offset inside the pass
	logic [pFifoDepthBit:0]   inFlight;				// Reads not yet in the FIFO
	logic                     rdPend;				// Read issued last cycle
	logic [pFifoDepthBit+1:0] fillSum;
	logic                     passEnd;

	assign fillSum   = (pFifoDepthBit+2)'(fifoCount) + (pFifoDepthBit+2)'(inFlight);
	assign ramRdEn   = dmaEn & (fillSum < cDepth);	// Stall on back-pressure
	assign ramRdAdrs = rdPtr;
	assign passEnd   = (rdOfs == dmaLen);
	assign fifoWr    = rdPend;						// RAM data is back now
	assign fifoWd    = ramRdData;
	assign fifoFlush = enD & ~dmaEn;				// Falling edge of enable
	assign dmaBusy   = dmaEn | (fifoCount != '0) | (inFlight != '0);

	always_ff @(posedge iSysClk)
	begin
		if (reset)
		begin
			enD      <= 1'b0;
			rdPend   <= 1'b0;
			inFlight <= '0;
			rdPtr    <= '0;
			rdOfs    <= '0;
			loopCnt  <= '0;
		end
		else
		begin
			enD    <= dmaEn;
			rdPend <= ramRdEn;

			case ({ramRdEn, rdPend})
				2'b10:   inFlight <= inFlight + 1'b1;
				2'b01:   inFlight <= inFlight - 1'b1;
				default: inFlight <= inFlight;
			endcase

			// Pointer sits at the start address while disabled
			if (!dmaEn)
			begin
				rdPtr <= dmaAdrs;
				rdOfs <= '0;
			end
			else if (ramRdEn)
			begin
				if (passEnd)
				begin
					rdPtr   <= dmaAdrs;					// Wrap to start
					rdOfs   <= '0;
					loopCnt <= loopCnt + 1'b1;
				end
				else
				begin
					rdPtr <= rdPtr + 1'b1;
					rdOfs <= rdOfs + 1'b1;
				end
			end
		end
	end

endmodule

//--- hdl/audioSampleFifo.sv
// Synchronous FIFO of sample words between the DMA and the serializer
// Read data falls through, so the head word is valid while not empty
// A flush pulse empties it in one cycle

module audioSampleFifo
	import audioTxPkg::*;
#(
	parameter int pFifoDepthBit = 3
)(
	input  logic                   fifoWr,
	input  tSampleWord             fifoWd,
	input  logic                   fifoRd,			// Pop the head word
	input  logic                   fifoFlush,
	output tSampleWord             fifoRdData,
	output logic                   fifoEmpty,
	output logic [pFifoDepthBit:0] fifoCount,		// Occupancy 0 to depth
	input  logic                   iSysClk,
	input  logic                   reset
);

	localparam int cDepth = 2**pFifoDepthBit;

	tSampleWord               mem [cDepth];
	logic [pFifoDepthBit-1:0] wrPtr;
	logic [pFifoDepthBit-1:0] rdPtr;
	logic                     doWr;
	logic                     doRd;

	assign fifoEmpty  = (fifoCount == '0);
	assign fifoRdData = mem[rdPtr];					// First word fall through
	assign doWr       = fifoWr & (fifoCount != cDepth);
	assign doRd       = fifoRd & ~fifoEmpty;

	always_ff @(posedge iSysClk)
	begin
		if (doWr)
			mem[wrPtr] <= fifoWd;
	end

	always_ff @(posedge iSysClk)
	begin
		if (reset || fifoFlush)						// Flush wins over push and pop
		begin
			wrPtr     <= '0;
			rdPtr     <= '0;
			fifoCount <= '0;
		end
		else
		begin
			if (doWr) wrPtr <= wrPtr + 1'b1;
			if (doRd) rdPtr <= rdPtr + 1'b1;
			case ({doWr, doRd})
				2'b10:   fifoCount <= fifoCount + 1'b1;
				2'b01:   fifoCount <= fifoCount - 1'b1;
				default: fifoCount <= fifoCount;
			endcase
		end
	end

endmodule

//--- hdl/audioTxSerializer.sv
// Serial audio output stage, left-justified three-wire format
// Makes the bit clock, frames left and right and shifts out MSB first
// One FIFO word per frame, a zero frame and an underrun count when empty

module audioTxSerializer
	import audioTxPkg::*;
#(
	parameter int pBitDiv = 2						// Clocks per half bit period
)(
	input  tSampleWord          fifoRdData,			// Head of FIFO
	input  logic                fifoEmpty,
	output logic                fifoRd,				// Pop at frame start
	output logic                oI2sBck,
	output logic                oI2sLrck,			// Low left, high right
	output logic                oI2sData,
	output logic [cCntBits-1:0] underrunCnt,
	input  logic                iSysClk,
	input  logic                reset
);

	localparam int cFrameBits = $bits(tSampleWord);	// 32 bit periods
	localparam int cBitCntW   = $clog2(cFrameBits);
	localparam int cDivBits   = $clog2(pBitDiv + 1);

	logic [cDivBits-1:0] divCnt;
	logic                halfEnd;					// Bit clock toggles here
	logic                fallEdge;
	logic [cBitCntW-1:0] bitCnt;					// Bit position in frame
	logic [cBitCntW-1:0] bitNext;
	logic                lastBit;
	logic                frameStart;
	tSampleWord          shiftReg;

	//----------------------------------------------------------
	// Bit clock and frame timing
	//----------------------------------------------------------
	assign halfEnd    = (divCnt == cDivBits'(pBitDiv - 1));
	assign fallEdge   = halfEnd & oI2sBck;
	assign lastBit    = (bitCnt == cBitCntW'(cFrameBits - 1));
	assign bitNext    = lastBit ? '0 : bitCnt + 1'b1;
	assign frameStart = fallEdge & lastBit;
	assign fifoRd     = frameStart & ~fifoEmpty;	// Data taken same cycle
	assign oI2sData   = shiftReg.raw[cFrameBits-1];	// MSB first

	always_ff @(posedge iSysClk)
	begin
		if (reset)
		begin
			divCnt  <= '0;
			oI2sBck <= 1'b0;
		end
		else if (halfEnd)
		begin
			divCnt  <= '0;
			oI2sBck <= ~oI2sBck;
		end
		else
			divCnt <= divCnt + 1'b1;
	end

	//----------------------------------------------------------
	// Shift out, all changes on the bit clock falling edge
	//----------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (reset)
		begin
			bitCnt      <= '0;							// Silent first frame, no pop
			oI2sLrck    <= 1'b0;
			shiftReg    <= '0;
			underrunCnt <= '0;
		end
		else if (fallEdge)
		begin
			bitCnt   <= bitNext;
			oI2sLrck <= (bitNext >= cSampleBits);	// Right half
			if (frameStart)
			begin
				if (fifoEmpty)
				begin
					shiftReg    <= '0;				// Silent frame
					underrunCnt <= underrunCnt + 1'b1;
				end
				else
				begin
					shiftReg.ch.left  <= fifoRdData.ch.left;
					shiftReg.ch.right <= fifoRdData.ch.right;
				end
			end
			else
				shiftReg.raw <= {shiftReg.raw[cFrameBits-2:0], 1'b0};
		end
	end

endmodule

//--- hdl/audioTxTop.sv
// Top level of the audio transmit block
// Bus slave with CSR and sample RAM, looping DMA, FIFO and serial output
// Parameters set here are passed down to every block

module audioTxTop
	import audioTxPkg::*;
#(
	parameter int                       pBlockAdrsMap   = 8,
	parameter int                       pCsrAdrsWidth   = 16,
	parameter int                       pBusAdrsBit     = 24,
	parameter int                       pCsrActiveWidth = 8,
	parameter logic [pBlockAdrsMap-1:0] pCsrMap         = 'h05,
	parameter logic [pBlockAdrsMap-1:0] pRamMap         = 'h06,
	parameter int                       pMemAdrsWidth   = 8,
	parameter int                       pFifoDepthBit   = 3,
	parameter int                       pBitDiv         = 2
)(
	input  logic [cBusDataBits-1:0] iSUsiWd,
	input  logic [pBusAdrsBit-1:0]  iSUsiAdrs,
	input  logic                    iSUsiWCke,
	output logic [cBusDataBits-1:0] oSUsiRd,		// Straight from the CSR
	output logic                    oSUsiREd,
	output logic                    oI2sBck,
	output logic                    oI2sLrck,
	output logic                    oI2sData,
	input  logic                    iSysClk,
	input  logic                    reset
);

	logic [pMemAdrsWidth-1:0] dmaAdrs, dmaLen, ramRdAdrs;
	logic                     dmaEn, dmaBusy, ramRdEn;
	logic [cCntBits-1:0]      loopCnt, underrunCnt;
	tSampleWord               ramRdData, fifoWd, fifoRdData;
	logic                     fifoWr, fifoRd, fifoFlush, fifoEmpty;
	logic [pFifoDepthBit:0]   fifoCount;

	audioTxCsr #(.pBlockAdrsMap(pBlockAdrsMap), .pCsrAdrsWidth(pCsrAdrsWidth),
		.pBusAdrsBit(pBusAdrsBit), .pCsrActiveWidth(pCsrActiveWidth),
		.pCsrMap(pCsrMap), .pMemAdrsWidth(pMemAdrsWidth)) uCsr (
		.iSUsiWd, .iSUsiAdrs, .iSUsiWCke, .oSUsiRd, .oSUsiREd,
		.dmaBusy, .loopCnt, .underrunCnt, .dmaAdrs, .dmaLen, .dmaEn,
		.iSysClk, .reset);

	audioSampleRam #(.pBlockAdrsMap(pBlockAdrsMap), .pCsrAdrsWidth(pCsrAdrsWidth),
		.pBusAdrsBit(pBusAdrsBit), .pRamMap(pRamMap),
		.pMemAdrsWidth(pMemAdrsWidth)) uRam (
		.iSUsiWd, .iSUsiAdrs, .iSUsiWCke, .ramRdAdrs, .ramRdEn, .ramRdData,
		.iSysClk);

	audioTxDma #(.pMemAdrsWidth(pMemAdrsWidth), .pFifoDepthBit(pFifoDepthBit)) uDma (
		.dmaAdrs, .dmaLen, .dmaEn, .ramRdAdrs, .ramRdEn, .ramRdData,
		.fifoCount, .fifoWr, .fifoWd, .fifoFlush, .dmaBusy, .loopCnt,
		.iSysClk, .reset);

	audioSampleFifo #(.pFifoDepthBit(pFifoDepthBit)) uFifo (
		.fifoWr, .fifoWd, .fifoRd, .fifoFlush, .fifoRdData, .fifoEmpty, .fifoCount,
		.iSysClk, .reset);

	audioTxSerializer #(.pBitDiv(pBitDiv)) uSer (
		.fifoRdData, .fifoEmpty, .fifoRd, .oI2sBck, .oI2sLrck, .oI2sData,
		.underrunCnt, .iSysClk, .reset);

endmodule

//--- dv/audioTxTb.sv
// Directed testbench for the audio transmit block
// Drives the bus slave, captures the serial audio output and checks six behaviors
// Top module audioTxTb, compiled with the sources in the file list

module audioTxTb
	import audioTxPkg::*;
();

	localparam logic [7:0] cCsrMap    = 8'h05;
	localparam logic [7:0] cRamMap    = 8'h06;
	localparam logic [7:0] cOtherMap  = 8'h07;	// Block with no slave
	localparam int         cMaxCycles = 40000;	// ~200 frames of 128 clocks plus margin
	localparam int         cSkipLimit = 8;		// Silent frames allowed before data

	logic [31:0] iSUsiWd;
	logic [23:0] iSUsiAdrs;
	logic        iSUsiWCke;
	logic [31:0] oSUsiRd;
	logic        oSUsiREd;
	logic        oI2sBck;
	logic        oI2sLrck;
	logic        oI2sData;
	logic        iSysClk;
	logic        reset;

	int          errCnt;
	int          testCnt;
	int          testErr;						// Errors in the running test
	int          cycleCnt = 0;
	logic [31:0] words [16];					// Sample words loaded into RAM

	audioTxTop #(.pCsrMap(cCsrMap), .pRamMap(cRamMap)) DUT (
		.iSUsiWd, .iSUsiAdrs, .iSUsiWCke, .oSUsiRd, .oSUsiREd,
		.oI2sBck, .oI2sLrck, .oI2sData, .iSysClk, .reset);

	initial
	begin
		iSysClk = 1'b0;
		forever #10 iSysClk = ~iSysClk;
	end

	// Run limit
	always @(posedge iSysClk)
	begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt >= cMaxCycles)
		begin
			$display("Run stopped after %0d cycles, a test never finished", cycleCnt);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	//------------------------------------------------------------
	// Bus and capture helpers
	//------------------------------------------------------------
	function automatic logic [23:0] csrAdrs(input logic [7:0] ofs);
		return {cCsrMap, 8'h00, ofs};
	endfunction

	function automatic logic [23:0] ramAdrs(input int idx);
		return {cRamMap, 6'h00, idx[7:0], 2'b00};	// Word index to byte address
	endfunction

	task automatic busWrite(input logic [23:0] adrs, input logic [31:0] data);
		@(posedge iSysClk);
		iSUsiAdrs <= adrs;
		iSUsiWd   <= data;
		iSUsiWCke <= 1'b1;						// One-cycle strobe
		@(posedge iSysClk);
		iSUsiWCke <= 1'b0;
	endtask

	task automatic busRead(input string name, input logic [23:0] adrs, output logic [31:0] data);
		@(posedge iSysClk);
		iSUsiAdrs <= adrs;
		@(posedge iSysClk);						// CSR registers the word here
		@(negedge iSysClk);
		if (!oSUsiREd)
		begin
			$display("%s: no read valid one cycle after address %h", name, adrs);
			testErr++;
		end
		data = oSUsiRd;
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		$display("Error in %s: expected %h, actual %h", name, exp, act);
		testErr++;
	endtask

	// One frame, MSB first, sampled on bit clock rise
	task automatic captureFrame(output logic [31:0] frame);
		@(negedge oI2sLrck);					// Left half opens the frame
		for (int i = 0; i < 2*cSampleBits; i++)
		begin
			@(posedge oI2sBck);
			frame = {frame[30:0], oI2sData};
		end
	endtask

	task automatic captureFirstData(input string name, output logic [31:0] frame);
		int skipped;
		skipped = 0;
		captureFrame(frame);
		while (frame == 32'h0 && skipped < cSkipLimit)	// Underrun frames at start
		begin
			skipped++;
			captureFrame(frame);
		end
		if (frame == 32'h0)
		begin
			$display("%s: no sample data after %0d silent frames", name, skipped + 1);
			testErr++;
		end
	endtask

	task automatic checkSetup(input string name, input logic [31:0] expAdrs,
		input logic [31:0] expLen, input logic [31:0] expEn);
		logic [31:0] rd;
		busRead(name, csrAdrs(cCsrDmaAdrs), rd);
		if (rd !== expAdrs)
			reportMismatch(name, expAdrs, rd);
		busRead(name, csrAdrs(cCsrDmaLen), rd);
		if (rd !== expLen)
			reportMismatch(name, expLen, rd);
		busRead(name, csrAdrs(cCsrDmaEn), rd);
		if (rd !== expEn)
			reportMismatch(name, expEn, rd);
	endtask

	task automatic finishTest(input string name);
		testCnt++;
		errCnt += testErr;
		if (testErr == 0)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, testErr);
		testErr = 0;
	endtask

	//------------------------------------------------------------
	// Tests
	//------------------------------------------------------------
	task automatic testResetValues();
		logic [31:0] rd;
		for (int i = 0; i < 7; i++)				// Offsets 0x00 to 0x18
		begin
			busRead("resetValues", csrAdrs(8'(i*4)), rd);
			if (rd !== 32'h0)
				reportMismatch("resetValues", 32'h0, rd);
		end
		captureFrame(rd);						// Output stays silent
		if (rd !== 32'h0)
			reportMismatch("resetValues", 32'h0, rd);
		finishTest("resetValues");
	endtask

	task automatic testRegAccess();
		logic [31:0] adrsVal;
		logic [31:0] lenVal;
		logic [31:0] enVal;
		adrsVal = $urandom;
		lenVal  = $urandom;
		enVal   = $urandom;
		busWrite(csrAdrs(cCsrDmaAdrs), adrsVal);
		busWrite(csrAdrs(cCsrDmaLen), lenVal);
		busWrite(csrAdrs(cCsrDmaEn), enVal);
		checkSetup("regAccess", adrsVal & 32'hff, lenVal & 32'hff, enVal & 32'h1);
		// Read-only offsets
		busWrite(csrAdrs(cCsrStatus), $urandom);
		busWrite(csrAdrs(cCsrLoopCnt), $urandom);
		busWrite(csrAdrs(cCsrUnderrun), $urandom);
		checkSetup("regAccess", adrsVal & 32'hff, lenVal & 32'hff, enVal & 32'h1);
		busWrite({cOtherMap, 8'h00, cCsrDmaAdrs}, ~adrsVal);	// Wrong block
		checkSetup("regAccess", adrsVal & 32'hff, lenVal & 32'hff, enVal & 32'h1);
		@(posedge iSysClk);
		iSUsiAdrs <= {cOtherMap, 8'h00, cCsrDmaAdrs};
		@(posedge iSysClk);
		@(negedge iSysClk);
		if (oSUsiREd)
		begin
			$display("regAccess: read valid came back for an address outside the CSR block");
			testErr++;
		end
		busWrite(csrAdrs(cCsrDmaEn), 32'h0);	// Park the DMA
		finishTest("regAccess");
	endtask

	task automatic testPlayback();
		logic [31:0] frame;
		for (int i = 0; i < 16; i++)
		begin
			words[i] = $urandom;
			if (words[i] == 32'h0)
				words[i] = 32'h1;				// Zero means silence
			busWrite(ramAdrs(20 + i), words[i]);
		end
		busWrite(csrAdrs(cCsrDmaAdrs), 32'd20);
		busWrite(csrAdrs(cCsrDmaLen), 32'd15);
		busWrite(csrAdrs(cCsrDmaEn), 32'd1);
		captureFirstData("playback", frame);
		for (int i = 0; i < 16; i++)
		begin
			if (i > 0)
				captureFrame(frame);
			if (frame !== words[i])
				reportMismatch("playback", words[i], frame);
		end
		finishTest("playback");
	endtask

	task automatic testLooping();
		logic [31:0] frame;
		logic [31:0] rd;
		logic [15:0] loopStart;
		logic [15:0] loops;
		busWrite(csrAdrs(cCsrDmaEn), 32'd0);	// Stop before shortening
		busWrite(csrAdrs(cCsrDmaLen), 32'd3);
		busRead("looping", csrAdrs(cCsrLoopCnt), rd);
		loopStart = rd[15:0];					// No passes while stopped
		busWrite(csrAdrs(cCsrDmaEn), 32'd1);
		captureFirstData("looping", frame);
		for (int i = 0; i < 12; i++)
		begin
			if (i > 0)
				captureFrame(frame);
			if (frame !== words[i % 4])			// Four words, three passes
				reportMismatch("looping", words[i % 4], frame);
		end
		busRead("looping", csrAdrs(cCsrLoopCnt), rd);
		loops = rd[15:0] - loopStart;			// Counter wraps at 16 bits
		if (loops < 16'd3)
		begin
			$display("Error in looping: expected at least 3 passes, actual %0d", loops);
			testErr++;
		end
		busRead("looping", csrAdrs(cCsrStatus), rd);
		if (rd !== 32'h1)
			reportMismatch("looping", 32'h1, rd);
		finishTest("looping");
	endtask

	task automatic testUnderrun();
		logic [31:0] rd;
		logic [31:0] frame;
		logic [15:0] startCnt;
		logic [15:0] diff;
		int          polls;
		busWrite(csrAdrs(cCsrDmaEn), 32'd0);
		polls = 0;
		busRead("underrun", csrAdrs(cCsrStatus), rd);
		while (rd[0] && polls < 20)				// Wait for the drain
		begin
			polls++;
			busRead("underrun", csrAdrs(cCsrStatus), rd);
		end
		if (rd[0])
		begin
			$display("underrun: busy did not clear after the DMA was disabled");
			testErr++;
		end
		busRead("underrun", csrAdrs(cCsrUnderrun), rd);
		startCnt = rd[15:0];
		for (int i = 0; i < 5; i++)
		begin
			captureFrame(frame);
			if (frame !== 32'h0)
				reportMismatch("underrun", 32'h0, frame);
		end
		busRead("underrun", csrAdrs(cCsrUnderrun), rd);
		diff = rd[15:0] - startCnt;				// Counter wraps at 16 bits
		if (diff < 16'd5)
		begin
			$display("Error in underrun: expected count to rise by at least 5, actual %0d", diff);
			testErr++;
		end
		finishTest("underrun");
	endtask

	task automatic testRestart();
		logic [31:0] frame;
		busWrite(csrAdrs(cCsrDmaAdrs), 32'd22);	// Third loaded word
		busWrite(csrAdrs(cCsrDmaEn), 32'd1);
		captureFirstData("restart", frame);
		if (frame !== words[2])
			reportMismatch("restart", words[2], frame);
		captureFrame(frame);
		if (frame !== words[3])
			reportMismatch("restart", words[3], frame);
		busWrite(csrAdrs(cCsrDmaEn), 32'd0);
		busWrite(csrAdrs(cCsrDmaEn), 32'd1);	// Back to the start address
		captureFirstData("restart", frame);
		if (frame !== words[2])
			reportMismatch("restart", words[2], frame);
		finishTest("restart");
	endtask

	//------------------------------------------------------------
	// Sequence
	//------------------------------------------------------------
	initial
	begin
		void'($urandom(32'ha174_4f4b));			// Single seed for the run
		errCnt    = 0;
		testCnt   = 0;
		testErr   = 0;
		reset     = 1'b1;
		iSUsiWd   = '0;
		iSUsiAdrs = '0;
		iSUsiWCke = 1'b0;
		repeat (3) @(posedge iSysClk);
		reset <= 1'b0;
		testResetValues();
		testRegAccess();
		testPlayback();
		testLooping();
		testUnderrun();
		testRestart();
		$display("Tests run: %0d, errors: %0d", testCnt, errCnt);
		if (errCnt == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- flist.f
hdl/audioTxPkg.sv
hdl/audioTxCsr.sv
hdl/audioSampleRam.sv
hdl/audioTxDma.sv
hdl/audioSampleFifo.sv
hdl/audioTxSerializer.sv
hdl/audioTxTop.sv
dv/audioTxTb.sv

//--- run.sh
#!/bin/sh
# Build and run the audio transmit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module audioTxTb -f flist.f -o audioTxSim

simOut=$(./obj_dir/audioTxSim)
echo "$simOut"

# Pass only when the testbench reports it
echo "$simOut" | grep -qF '*** TEST PASSED ***'
